/* src/mm_macros.svh */
/* Size macros for the block matrix multiplier
   Element format, tile edge, matrix dimensions and memory depth */
`ifndef MM_MACROS_SVH
`define MM_MACROS_SVH

// Signed Q8.8 element
`define MM_WIDTH 16
`define MM_FRAC 8

// Tile edge of the output blocks
`define MM_BLOCK 2

// Shared inner dimension of A and B
`define MM_INNER 4
`define MM_ROWS_A 6
`define MM_COLS_B 6

// Block rows of C and block columns of C
`define MM_BLK_ROWS (`MM_ROWS_A / `MM_BLOCK)
`define MM_BLK_COLS (`MM_COLS_B / `MM_BLOCK)

// One word per block and inner index
`define MM_MEM_DEPTH (`MM_BLK_ROWS * `MM_INNER)
`define MM_ACC_WIDTH 40

`endif

/* src/mm_types_pkg.sv */
/* Data types of the block matrix multiplier
   Elements, memory slices, accumulators and output tiles */
package mm_types_pkg;

`include "mm_macros.svh"

    // One signed Q8.8 value
    typedef logic signed [`MM_WIDTH-1:0] elem_t;

    // Column of an A block row at one inner index, element r at [r]
    typedef elem_t [`MM_BLOCK-1:0] a_slice_t;

    // Row of a B block column at one inner index, element c at [c]
    typedef elem_t [`MM_BLOCK-1:0] b_slice_t;

    // Full precision sum over the inner dimension
    typedef logic signed [`MM_ACC_WIDTH-1:0] acc_t;

    // Row major tile, (0,0) in the low 16 bits
    typedef elem_t [`MM_BLOCK-1:0][`MM_BLOCK-1:0] tile_t;

endpackage

/* src/mm_ctrl_pkg.sv */
/* Control types of the block matrix multiplier
   Sequencer state, memory addresses and loop counters */
package mm_ctrl_pkg;

`include "mm_macros.svh"

    typedef enum logic [1:0] {
        IDLE,   // Waiting for start, loading allowed
        RUN,    // Issuing slice reads
        FINISH  // All reads issued, draining tiles
    } seq_state_t;

    // Word address into either tile memory
    typedef logic [$clog2(`MM_MEM_DEPTH)-1:0] mem_addr_t;

    // Block row or block column of C
    typedef logic [$clog2(`MM_BLK_ROWS)-1:0] blk_idx_t;

    // Position along the inner dimension
    typedef logic [$clog2(`MM_INNER)-1:0] k_idx_t;

endpackage

/* src/tile_mem.sv */
/* Inferred one-write one-read memory with registered read
   Word type set per instance */
`timescale 1ns/1ns

`include "mm_macros.svh"

module tile_mem #(
    parameter type word_t = mm_types_pkg::a_slice_t,
    parameter int  DEPTH  = `MM_MEM_DEPTH
) (
    input  logic                  clk,
    input  logic                  we,     // Load strobe, never stalls
    input  mm_ctrl_pkg::mem_addr_t waddr,
    input  word_t                 wdata,
    input  logic                  rd_en,  // From the sequencer
    input  mm_ctrl_pkg::mem_addr_t raddr,
    output word_t                 rdata
);

    word_t mem [DEPTH]; // No reset on contents

    // Write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Read port, one cycle latency, holds value between reads
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rdata <= mem[raddr];
        end
    end

endmodule

/* src/block_sequencer.sv */
/* Block sequencer for the matrix multiplier
   Walks bi, bj and k, issues memory reads with slice flags, tracks tiles and done */
`timescale 1ns/1ns

`include "mm_macros.svh"

module block_sequencer (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    input  logic                   acc_ready,     // Array can take the next slices
    output logic                   rd_en,
    output mm_ctrl_pkg::mem_addr_t a_raddr,
    output mm_ctrl_pkg::mem_addr_t b_raddr,
    output logic                   slice_valid,   // Memory data valid this cycle
    output logic                   slice_first,
    output logic                   slice_last,
    input  logic                   tile_accepted, // Output handshake completed
    output logic                   busy,
    output logic                   done
);

    localparam mm_ctrl_pkg::blk_idx_t BI_LAST = mm_ctrl_pkg::blk_idx_t'(`MM_BLK_ROWS - 1);
    localparam mm_ctrl_pkg::blk_idx_t BJ_LAST = mm_ctrl_pkg::blk_idx_t'(`MM_BLK_COLS - 1);
    localparam mm_ctrl_pkg::k_idx_t   K_LAST  = mm_ctrl_pkg::k_idx_t'(`MM_INNER - 1);

    mm_ctrl_pkg::seq_state_t state;
    mm_ctrl_pkg::blk_idx_t   bi;      // Issue side block row
    mm_ctrl_pkg::blk_idx_t   bj;      // Issue side block column
    mm_ctrl_pkg::k_idx_t     k;
    mm_ctrl_pkg::blk_idx_t   out_bi;  // Tile being handed out
    mm_ctrl_pkg::blk_idx_t   out_bj;
    logic                    rd_first; // Flags travelling with the read
    logic                    rd_last;
    logic                    issue;
    logic                    last_issue;
    logic                    out_last;

    // Reads go out only while the array has room
    assign issue      = (state == mm_ctrl_pkg::RUN) && acc_ready;
    assign last_issue = (bi == BI_LAST) && (bj == BJ_LAST) && (k == K_LAST);
    assign out_last   = (out_bi == BI_LAST) && (out_bj == BJ_LAST);
    assign busy       = (state != mm_ctrl_pkg::IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state       <= mm_ctrl_pkg::IDLE;
            bi          <= '0;
            bj          <= '0;
            k           <= '0;
            out_bi      <= '0;
            out_bj      <= '0;
            rd_en       <= 1'b0;
            rd_first    <= 1'b0;
            rd_last     <= 1'b0;
            slice_valid <= 1'b0;
            slice_first <= 1'b0;
            slice_last  <= 1'b0;
            done        <= 1'b0;
        end else begin
            // Read stage
            rd_en    <= issue;
            rd_first <= issue && (k == '0);
            rd_last  <= issue && (k == K_LAST);
            // Delayed one more cycle to meet the memory data
            slice_valid <= rd_en;
            slice_first <= rd_first;
            slice_last  <= rd_last;
            done        <= 1'b0; // Single cycle pulse

            case (state)
                mm_ctrl_pkg::IDLE: begin
                    if (start) begin
                        state <= mm_ctrl_pkg::RUN;
                    end
                end
                mm_ctrl_pkg::RUN: begin
                    if (issue) begin
                        if (k == K_LAST) begin
                            k <= '0;
                            if (bj == BJ_LAST) begin
                                bj <= '0;
                                bi <= (bi == BI_LAST) ? '0 : bi + 1'b1; // Wraps for the next run
                            end else begin
                                bj <= bj + 1'b1;
                            end
                        end else begin
                            k <= k + 1'b1;
                        end
                        if (last_issue) begin
                            state <= mm_ctrl_pkg::FINISH;
                        end
                    end
                end
                mm_ctrl_pkg::FINISH: begin
                    // Wait for the final tile to leave
                    if (tile_accepted && out_last) begin
                        state <= mm_ctrl_pkg::IDLE;
                        done  <= 1'b1;
                    end
                end
                default: state <= mm_ctrl_pkg::IDLE;
            endcase

            // Output side tile count, bi then bj order
            if (tile_accepted) begin
                if (out_bj == BJ_LAST) begin
                    out_bj <= '0;
                    out_bi <= (out_bi == BI_LAST) ? '0 : out_bi + 1'b1;
                end else begin
                    out_bj <= out_bj + 1'b1;
                end
            end
        end
    end

    // Addresses by the layout rule, word = block * INNER + k
    always_ff @(posedge clk) begin
        if (issue) begin
            a_raddr <= mm_ctrl_pkg::mem_addr_t'(bi * `MM_INNER + k);
            b_raddr <= mm_ctrl_pkg::mem_addr_t'(bj * `MM_INNER + k);
        end
    end

endmodule

/* src/mac_array.sv */
/* BLOCK x BLOCK outer product accumulator
   Scale and saturate stage into a held output tile register */
`timescale 1ns/1ns

`include "mm_macros.svh"

module mac_array (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  slice_valid,
    input  logic                  slice_first, // Restart sums with this slice
    input  logic                  slice_last,  // Tile complete after this slice
    input  mm_types_pkg::a_slice_t a_slice,
    input  mm_types_pkg::b_slice_t b_slice,
    output logic                  acc_ready,
    output logic                  c_valid,
    input  logic                  c_ready,
    output mm_types_pkg::tile_t   c_data
);

    localparam int BLOCK  = `MM_BLOCK;
    localparam int PROD_W = 2 * `MM_WIDTH;

    // Q8.8 output range in accumulator terms
    localparam mm_types_pkg::acc_t SAT_MAX = (1 <<< (`MM_WIDTH - 1)) - 1;
    localparam mm_types_pkg::acc_t SAT_MIN = -(1 <<< (`MM_WIDTH - 1));

    logic signed [PROD_W-1:0] prod     [BLOCK][BLOCK];
    mm_types_pkg::acc_t       acc      [BLOCK][BLOCK];
    mm_types_pkg::acc_t       sum_next [BLOCK][BLOCK];

    // Floor shift, then clamp to 16 bits
    function automatic mm_types_pkg::elem_t scale_sat(input mm_types_pkg::acc_t sum);
        mm_types_pkg::acc_t shifted;
        shifted = sum >>> `MM_FRAC;
        if (shifted > SAT_MAX) begin
            scale_sat = mm_types_pkg::elem_t'(SAT_MAX);   // 7FFF
        end else if (shifted < SAT_MIN) begin
            scale_sat = mm_types_pkg::elem_t'(SAT_MIN);   // 8000
        end else begin
            scale_sat = mm_types_pkg::elem_t'(shifted);
        end
    endfunction

    // Room when the tile register is empty or leaving now
    assign acc_ready = !c_valid || c_ready;

    always_comb begin
        for (int r = 0; r < BLOCK; r++) begin
            for (int c = 0; c < BLOCK; c++) begin
                prod[r][c] = $signed(a_slice[r]) * $signed(b_slice[c]); // Full Q16.16 product
                sum_next[r][c] = mm_types_pkg::acc_t'(prod[r][c])
                               + (slice_first ? mm_types_pkg::acc_t'(0) : acc[r][c]);
            end
        end
    end

    // Accumulators, restarted by slice_first
    always_ff @(posedge clk) begin
        if (slice_valid) begin
            for (int r = 0; r < BLOCK; r++) begin
                for (int c = 0; c < BLOCK; c++) begin
                    acc[r][c] <= sum_next[r][c];
                end
            end
        end
    end

    // Tile register, loaded with the final sums including the last slice
    always_ff @(posedge clk) begin
        if (slice_valid && slice_last) begin
            for (int r = 0; r < BLOCK; r++) begin
                for (int c = 0; c < BLOCK; c++) begin
                    c_data[r][c] <= scale_sat(sum_next[r][c]);
                end
            end
        end
    end

    // Sequencer gating on acc_ready keeps a new last slice off a full register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            c_valid <= 1'b0;
        end else if (slice_valid && slice_last) begin
            c_valid <= 1'b1;
        end else if (c_ready) begin
            c_valid <= 1'b0; // Tile taken
        end
    end

endmodule

/* src/mm_top.sv */
/* Top level of the block matrix multiplier
   A and B memories, block sequencer and MAC array */
`timescale 1ns/1ns

`include "mm_macros.svh"

module mm_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start,
    output logic                   busy,
    output logic                   done,
    input  logic                   in_we,    // A memory load
    input  mm_ctrl_pkg::mem_addr_t in_waddr,
    input  mm_types_pkg::a_slice_t in_wdata,
    input  logic                   wb_we,    // B memory load
    input  mm_ctrl_pkg::mem_addr_t wb_waddr,
    input  mm_types_pkg::b_slice_t wb_wdata,
    output logic                   c_valid,
    input  logic                   c_ready,
    output mm_types_pkg::tile_t    c_data
);

    logic                   rd_en;
    mm_ctrl_pkg::mem_addr_t a_raddr;
    mm_ctrl_pkg::mem_addr_t b_raddr;
    mm_types_pkg::a_slice_t a_slice;
    mm_types_pkg::b_slice_t b_slice;
    logic                   slice_valid;
    logic                   slice_first;
    logic                   slice_last;
    logic                   acc_ready;
    logic                   tile_accepted;

    assign tile_accepted = c_valid && c_ready; // Output transfer this cycle

    tile_mem #(
        .word_t (mm_types_pkg::a_slice_t),
        .DEPTH  (`MM_MEM_DEPTH)
    ) in_mem_i (
        .clk   (clk),
        .we    (in_we),
        .waddr (in_waddr),
        .wdata (in_wdata),
        .rd_en (rd_en),
        .raddr (a_raddr),
        .rdata (a_slice)
    );

    tile_mem #(
        .word_t (mm_types_pkg::b_slice_t),
        .DEPTH  (`MM_MEM_DEPTH)
    ) wb_mem_i (
        .clk   (clk),
        .we    (wb_we),
        .waddr (wb_waddr),
        .wdata (wb_wdata),
        .rd_en (rd_en),
        .raddr (b_raddr),
        .rdata (b_slice)
    );

    block_sequencer seq_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .start         (start),
        .acc_ready     (acc_ready),
        .rd_en         (rd_en),
        .a_raddr       (a_raddr),
        .b_raddr       (b_raddr),
        .slice_valid   (slice_valid),
        .slice_first   (slice_first),
        .slice_last    (slice_last),
        .tile_accepted (tile_accepted),
        .busy          (busy),
        .done          (done)
    );

    mac_array mac_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .slice_valid (slice_valid),
        .slice_first (slice_first),
        .slice_last  (slice_last),
        .a_slice     (a_slice),
        .b_slice     (b_slice),
        .acc_ready   (acc_ready),
        .c_valid     (c_valid),
        .c_ready     (c_ready),
        .c_data      (c_data)
    );

endmodule

/* tests/mm_top_sva.sv */
/* Output handshake and done assertions for mm_top
   Bound into every mm_top instance */
`timescale 1ns/1ns

module mm_top_sva (
    input logic                clk,
    input logic                rst_n,
    input logic                busy,
    input logic                done,
    input logic                c_valid,
    input logic                c_ready,
    input mm_types_pkg::tile_t c_data
);

    int err_count = 0; // Failed checks so far

    // Tile held while the sink stalls
    hold_tile: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid && !c_ready |=> c_valid && $stable(c_data))
        else begin
            $error("c_valid dropped or c_data changed under back-pressure");
            err_count++;
        end

    // One cycle only
    done_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else begin
            $error("done held for more than one cycle");
            err_count++;
        end

    valid_busy: assert property (@(posedge clk) disable iff (!rst_n)
        c_valid |-> busy)
        else begin
            $error("c_valid while busy is low");
            err_count++;
        end

endmodule

bind mm_top mm_top_sva sva_i (.*);

/* tests/tb_mm_top.sv */
/* Testbench for mm_top
   Reads matrices and expected tiles from the stim file, runs and checks each test */
`timescale 1ns/1ns

`include "mm_macros.svh"

module tb_mm_top;

    localparam int NUM_TESTS = 6;
    localparam int NUM_TILES = (`MM_BLK_ROWS) * (`MM_BLK_COLS);
    localparam int RUN_CYC   = NUM_TILES * `MM_INNER + 3;
    localparam int LIMIT     = RUN_CYC * 4;       // Per test cycle budget

    logic                   clk = 1'b0;
    logic                   rst_n;
    logic                   start;
    logic                   busy;
    logic                   done;
    logic                   in_we;
    mm_ctrl_pkg::mem_addr_t in_waddr;
    mm_types_pkg::a_slice_t in_wdata;
    logic                   wb_we;
    mm_ctrl_pkg::mem_addr_t wb_waddr;
    mm_types_pkg::b_slice_t wb_wdata;
    logic                   c_valid;
    logic                   c_ready;
    mm_types_pkg::tile_t    c_data;

    mm_types_pkg::a_slice_t a_words [`MM_MEM_DEPTH];
    mm_types_pkg::b_slice_t b_words [`MM_MEM_DEPTH];
    mm_types_pkg::tile_t    exp_tile [NUM_TILES];
    int                     fd;
    int                     cyc = 0;     // Free running edge count
    int                     errors;      // In the current test
    int                     pass_cnt = 0;
    int                     fail_cnt = 0;
    logic [15:0]            lfsr = 16'd64449;

    mm_top dut_i (.*);

    always #5 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    // Fibonacci LFSR with taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic check_tile(input mm_types_pkg::tile_t got, input mm_types_pkg::tile_t exp,
                              input int idx);
        if (got !== exp) begin
            $display("[FAIL] c_data tile %0d: got %h expected %h", idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("[FAIL] %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_cycles(input int got, input int exp, input string what);
        if (got != exp) begin
            $display("%s came %0d cycles after start instead of %0d", what, got, exp);
            errors++;
        end
    endtask

    // Done exactly once after the last tile and nothing trailing
    task automatic check_done(input int tiles_at_done, input int extra_done,
                              input int extra_tiles);
        if (tiles_at_done != NUM_TILES) begin
            $display("done came after %0d tiles instead of %0d", tiles_at_done, NUM_TILES);
            errors++;
        end
        if (extra_done != 0) begin
            $display("done pulsed again after the end of the run");
            errors++;
        end
        if (extra_tiles != 0) begin
            $display("an extra tile appeared after done");
            errors++;
        end
    endtask

    // Next hex token with comment lines skipped
    task automatic read_hex(output logic [63:0] val);
        string tok;
        string rest;
        int    rc;
        bit    got;
        got = 0;
        val = '0;
        while (!got) begin
            rc = $fscanf(fd, "%s", tok);
            if (rc != 1) begin
                $display("Stim file ended early");
                errors++;
                got = 1;
            end else if (tok.substr(0, 0) == "#") begin
                rc = $fgets(rest, fd);
            end else begin
                rc = $sscanf(tok, "%h", val);
                got = 1;
            end
        end
    endtask

    task automatic load_mems();
        if (busy) begin
            $display("Memories loaded while the engine was busy");
            errors++;
        end
        for (int w = 0; w < `MM_MEM_DEPTH; w++) begin
            @(posedge clk);
            #1;
            in_we    = 1'b1;
            in_waddr = mm_ctrl_pkg::mem_addr_t'(w);
            in_wdata = a_words[w];
            wb_we    = 1'b1;
            wb_waddr = mm_ctrl_pkg::mem_addr_t'(w);
            wb_wdata = b_words[w];
        end
        @(posedge clk);
        #1;
        in_we = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic pulse_start(output int start_cyc);
        @(posedge clk);
        #1 start = 1'b1;
        @(posedge clk);
        #1 start = 1'b0;
        start_cyc = cyc;   // Count of the edge that sampled start
        check_bit(busy, 1'b1, "busy");
    endtask

    task automatic run_test(input int num, input int mode);
        logic [63:0] v;
        int          start_cyc;
        int          tiles;
        int          n;
        int          extra_done;
        int          extra_tiles;
        int          sva_before;
        bit          finished;
        errors = 0;
        sva_before = dut_i.sva_i.err_count;
        for (int w = 0; w < `MM_MEM_DEPTH; w++) begin
            read_hex(v);
            a_words[w] = mm_types_pkg::a_slice_t'(v);
        end
        for (int w = 0; w < `MM_MEM_DEPTH; w++) begin
            read_hex(v);
            b_words[w] = mm_types_pkg::b_slice_t'(v);
        end
        for (int t = 0; t < NUM_TILES; t++) begin
            read_hex(v);
            exp_tile[t] = v;
        end
        c_ready = 1'b1;
        load_mems();
        if (mode == 2) begin
            c_ready = 1'b0;             // First tile waits in the output register
            pulse_start(start_cyc);
            repeat (15) @(posedge clk); // Well inside the run
            #1;
            check_bit(c_valid, 1'b1, "c_valid");
            rst_n = 1'b0;
            repeat (5) @(posedge clk);
            #1 rst_n = 1'b1;
            c_ready = 1'b1;
            @(negedge clk);
            check_bit(busy, 1'b0, "busy");
            check_bit(c_valid, 1'b0, "c_valid");
            check_bit(done, 1'b0, "done");
        end
        pulse_start(start_cyc);
        if (mode == 1) begin
            lfsr    = lfsr_next(lfsr);
            c_ready = lfsr[15];
        end
        tiles    = 0;
        n        = 0;
        finished = 0;
        while (!finished && n < LIMIT) begin
            @(negedge clk);
            if (c_valid && c_ready) begin
                if (tiles < NUM_TILES) begin
                    check_tile(c_data, exp_tile[tiles], tiles);
                    if (mode != 1) begin
                        check_cycles(cyc - start_cyc, `MM_INNER + 2 + `MM_INNER * tiles,
                                     $sformatf("tile %0d", tiles));
                    end
                end
                tiles++;
            end
            if (done) begin
                finished = 1;
                check_bit(busy, 1'b0, "busy");
                if (mode != 1) begin
                    check_cycles(cyc - start_cyc, RUN_CYC, "done");
                end
            end
            @(posedge clk);
            #1;
            if (mode == 1) begin
                lfsr    = lfsr_next(lfsr);
                c_ready = lfsr[15];
            end
            n++;
        end
        c_ready = 1'b1;
        if (!finished) begin
            $display("Timeout in test %0d: %0d of %0d tiles seen and no done", num, tiles,
                     NUM_TILES);
            errors++;
        end else begin
            extra_done  = 0;
            extra_tiles = 0;
            repeat (4) begin
                @(negedge clk);
                extra_done  += done;
                extra_tiles += c_valid;
            end
            check_done(tiles, extra_done, extra_tiles);
        end
        if (dut_i.sva_i.err_count != sva_before) begin
            $display("Bound assertions failed during test %0d", num);
            errors++;
        end
        if (errors == 0) begin
            $display("test %0d mode %0d: ok", num, mode);
            pass_cnt++;
        end else begin
            $display("test %0d mode %0d: %0d errors", num, mode, errors);
            fail_cnt++;
        end
    endtask

    // Watchdog sized from the run length plus loading
    initial begin
        #((NUM_TESTS * (LIMIT + 2 * `MM_MEM_DEPTH + 40) + 100) * 10);
        $display("Watchdog expired before all tests finished");
        $display("Testbench failed");
        $finish;
    end

    initial begin
        logic [63:0] num;
        logic [63:0] mode;
        rst_n    = 1'b0;
        start    = 1'b0;
        in_we    = 1'b0;
        in_waddr = '0;
        in_wdata = '0;
        wb_we    = 1'b0;
        wb_waddr = '0;
        wb_wdata = '0;
        c_ready  = 1'b1;
        errors   = 0;
        fd = $fopen("tests/mm_stim.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the stim file");
            fail_cnt++;
        end else begin
            repeat (5) @(posedge clk);
            #1 rst_n = 1'b1;
            for (int t = 0; t < NUM_TESTS; t++) begin
                read_hex(num);
                read_hex(mode);
                run_test(int'(num), int'(mode));
            end
            $fclose(fd);
        end
        $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

/* mm_engine.f */
+incdir+src
src/mm_types_pkg.sv
src/mm_ctrl_pkg.sv
src/tile_mem.sv
src/block_sequencer.sv
src/mac_array.sv
src/mm_top.sv
tests/mm_top_sva.sv
tests/tb_mm_top.sv

/* Bender.yml */
package:
  name: mm_engine

sources:
  - include_dirs:
      - src
    files:
      - src/mm_types_pkg.sv
      - src/mm_ctrl_pkg.sv
      - src/tile_mem.sv
      - src/block_sequencer.sv
      - src/mac_array.sv
      - src/mm_top.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/mm_top_sva.sv
      - tests/tb_mm_top.sv

/* tests/mm_stim.txt */
# test_no mode(0 ready high, 1 random ready, 2 reset mid-run), then 12 A words, 12 B words
# then 9 expected tiles in bi-then-bj order, all hex
1 0
02000100 02000100 02000100 02000100 04000300 04000300
04000300 04000300 06000500 06000500 06000500 06000500
00800040 00800040 00800040 00800040 010000C0 010000C0
010000C0 010000C0 01800140 01800140 01800140 01800140
0400020002000100 0800060004000300 0C000A0006000500
0800040006000300 10000C000C000900 1800140012000F00
0C0006000A000500 1800120014000F00 24001E001E001900
2 0
FFFF0001 00000000 00000000 00000000 0180FF80 00000000
00000000 00000000 0003FE00 00000000 00000000 00000000
FF000080 00000000 00000000 00000000 FFFF0001 00000000
00000000 00000000 FF400300 00000000 00000000 00000000
0001FFFFFFFF0000 0000FFFFFFFF0000 0000FFFDFFFF0003
FE8000C00080FFC0 FFFE00010000FFFF FEE004800060FE80
FFFD00010200FF00 FFFF00000002FFFE FFFD00090180FA00
3 0
C0004000 C0004000 C0004000 C0004000 80000100 80000100
80000100 80000100 00407FFF 00407FFF 00407FFF 00407FFF
00400100 00400100 00400100 00400100 80007FFF 80007FFF
80007FFF 80007FFF FFC00200 FFC00200 FFC00200 FFC00200
C000800040007FFF 7FFF800080007FFF 40008000C0007FFF
8000800001000400 7FFF800080007FFF 7FFF8000FF000800
004001007FFF7FFF 80007FFF80007FFF FFC0020080017FFF
4 1
FFFF0001 00000000 00000000 00000000 0180FF80 00000000
00000000 00000000 0003FE00 00000000 00000000 00000000
FF000080 00000000 00000000 00000000 FFFF0001 00000000
00000000 00000000 FF400300 00000000 00000000 00000000
0001FFFFFFFF0000 0000FFFFFFFF0000 0000FFFDFFFF0003
FE8000C00080FFC0 FFFE00010000FFFF FEE004800060FE80
FFFD00010200FF00 FFFF00000002FFFE FFFD00090180FA00
5 0
02000100 02000100 02000100 02000100 04000300 04000300
04000300 04000300 06000500 06000500 06000500 06000500
00800040 00800040 00800040 00800040 010000C0 010000C0
010000C0 010000C0 01800140 01800140 01800140 01800140
0400020002000100 0800060004000300 0C000A0006000500
0800040006000300 10000C000C000900 1800140012000F00
0C0006000A000500 1800120014000F00 24001E001E001900
6 2
C0004000 C0004000 C0004000 C0004000 80000100 80000100
80000100 80000100 00407FFF 00407FFF 00407FFF 00407FFF
00400100 00400100 00400100 00400100 80007FFF 80007FFF
80007FFF 80007FFF FFC00200 FFC00200 FFC00200 FFC00200
C000800040007FFF 7FFF800080007FFF 40008000C0007FFF
8000800001000400 7FFF800080007FFF 7FFF8000FF000800
004001007FFF7FFF 80007FFF80007FFF FFC0020080017FFF
